/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int FETCH_NUM     = 2; // instruction slots per fetch
	localparam int RESOLVE_DEPTH = 4; // queue entries, also the back end's starting credits

	// redirect kind reported per fetch slot
	typedef enum logic [1:0] {
		ControlFlow_None    = 2'd0,
		ControlFlow_Branch  = 2'd1, // predicted-taken conditional branch
		ControlFlow_JumpImm = 2'd2, // j, jal
		ControlFlow_JumpReg = 2'd3  // jr, jalr and returns
	} controlflow_t;

endpackage

`default_nettype wire

/* source/branch_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_decoder (
	input  logic [31:0] instr,
	output logic [31:0] imm_branch,
	output logic [31:0] imm_jump,
	output logic        is_branch,
	output logic        is_return,
	output logic        is_call,
	output logic        is_jump_i,
	output logic        is_jump_r
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic       op_jr;
	logic       op_jalr;
	logic       op_jal;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];

	assign op_jr   = (opcode == 6'b000000) && (funct == 6'b001000);
	assign op_jalr = (opcode == 6'b000000) && (funct == 6'b001001);
	assign op_jal  = (opcode == 6'b000011);

	always_comb begin
		is_branch = 1'b0;
		case (opcode)
			6'b000100, 6'b000101: is_branch = 1'b1; // beq, bne
			6'b000110, 6'b000111: is_branch = 1'b1; // blez, bgtz
			// regimm: bltz, bgez, bltzal, bgezal
			6'b000001: is_branch = (rt[3:1] == 3'b000);
			default: ;
		endcase
	end

	assign is_jump_i = (opcode == 6'b000010) || op_jal;
	assign is_jump_r = op_jr || op_jalr; // returns included, predictor separates them
	assign is_call   = op_jal || op_jalr;
	assign is_return = op_jr && (rs == 5'd31); // jr $ra

	assign imm_branch = {{14{instr[15]}}, instr[15:0], 2'b00}; // word offset to bytes
	assign imm_jump   = {4'b0000, instr[25:0], 2'b00};

endmodule

`default_nettype wire

/* branch_predictor/bht.sv */
`timescale 1ns/10ps
`default_nettype none

module bht #(
	parameter int ENTRIES_NUM = 1024
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [31:0]                   pc,
	input  logic                          bht_we,
	input  logic [31:0]                   bht_pc,
	input  logic                          bht_taken,
	output logic [cpu_pkg::FETCH_NUM-1:0] bht_valid,
	output logic [cpu_pkg::FETCH_NUM-1:0] bht_taken_pred
);

	localparam int IDX_W = $clog2(ENTRIES_NUM);

	logic [1:0]             counter_q [ENTRIES_NUM];
	logic [ENTRIES_NUM-1:0] valid_q;
	logic [IDX_W-1:0]       wr_idx;
	logic [1:0]             wr_count;

	assign wr_idx = bht_pc[IDX_W+1:2]; // word address modulo table size

	always_comb begin
		wr_count = bht_taken ? 2'b10 : 2'b01; // new entry starts weak in the update direction
		if (valid_q[wr_idx]) begin
			wr_count = counter_q[wr_idx];
			if (bht_taken && counter_q[wr_idx] != 2'b11) begin
				wr_count = counter_q[wr_idx] + 2'd1;
			end else if (!bht_taken && counter_q[wr_idx] != 2'b00) begin
				wr_count = counter_q[wr_idx] - 2'd1;
			end
		end
	end

	for (genvar i = 0; i < cpu_pkg::FETCH_NUM; i++) begin : gen_read
		logic [IDX_W-1:0] rd_idx;

		assign rd_idx            = pc[IDX_W+1:2] + IDX_W'(i);
		assign bht_valid[i]      = valid_q[rd_idx];
		assign bht_taken_pred[i] = counter_q[rd_idx][1]; // msb is the direction
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else if (bht_we) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (bht_we) begin
			counter_q[wr_idx] <= wr_count;
		end
	end

endmodule

`default_nettype wire

/* branch_predictor/btb.sv */
`timescale 1ns/10ps
`default_nettype none

module btb #(
	parameter int ENTRIES_NUM = 8
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [31:0]                         pc,
	input  logic                                btb_we,
	input  logic [31:0]                         btb_pc,
	input  logic [31:0]                         btb_target,
	output logic [cpu_pkg::FETCH_NUM-1:0]       btb_hit,
	output logic [cpu_pkg::FETCH_NUM-1:0][31:0] btb_target_pred
);

	localparam int PTR_W = $clog2(ENTRIES_NUM);

	logic [ENTRIES_NUM-1:0]       valid_q;
	logic [ENTRIES_NUM-1:0][31:0] tag_q; // full pc, no aliasing
	logic [ENTRIES_NUM-1:0][31:0] target_q;
	logic [PTR_W-1:0]             victim_q;
	logic [PTR_W-1:0]             wr_idx;
	logic                         wr_hit;

	// lookup for both fetch slots
	always_comb begin
		logic [31:0] slot_pc;

		slot_pc = '0;
		for (int i = 0; i < cpu_pkg::FETCH_NUM; i++) begin
			slot_pc            = pc + 32'(4 * i);
			btb_hit[i]         = 1'b0;
			btb_target_pred[i] = '0;
			for (int e = 0; e < ENTRIES_NUM; e++) begin
				if (valid_q[e] && tag_q[e] == slot_pc) begin
					btb_hit[i]         = 1'b1;
					btb_target_pred[i] = target_q[e];
				end
			end
		end
	end

	// existing entry is refreshed in place, otherwise the victim is taken
	always_comb begin
		wr_hit = 1'b0;
		wr_idx = victim_q;
		for (int e = 0; e < ENTRIES_NUM; e++) begin
			if (valid_q[e] && tag_q[e] == btb_pc) begin
				wr_hit = 1'b1;
				wr_idx = PTR_W'(e);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q  <= '0;
			victim_q <= '0;
		end else if (btb_we) begin
			valid_q[wr_idx] <= 1'b1;
			if (!wr_hit) begin
				victim_q <= (victim_q == PTR_W'(ENTRIES_NUM - 1)) ? '0 : victim_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (btb_we) begin
			tag_q[wr_idx]    <= btb_pc;
			target_q[wr_idx] <= btb_target;
		end
	end

endmodule

`default_nettype wire

/* branch_predictor/ras.sv */
`timescale 1ns/10ps
`default_nettype none

module ras #(
	parameter int ENTRIES_NUM = 8
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        flush,
	input  logic        push_req,
	input  logic        pop_req,
	input  logic [31:0] push_data,
	output logic        ras_valid,
	output logic [31:0] ras_top
);

	localparam int PTR_W = $clog2(ENTRIES_NUM);
	localparam int CNT_W = $clog2(ENTRIES_NUM + 1);

	logic [31:0]      stack_q [ENTRIES_NUM];
	logic [PTR_W-1:0] top_q;
	logic [PTR_W-1:0] top_next;
	logic [PTR_W-1:0] top_prev;
	logic [CNT_W-1:0] count_q;

	assign ras_valid = (count_q != '0);
	assign ras_top   = ras_valid ? stack_q[top_q] : '0; // empty stack predicts zero

	assign top_next = (top_q == PTR_W'(ENTRIES_NUM - 1)) ? '0 : top_q + 1'b1;
	assign top_prev = (top_q == '0) ? PTR_W'(ENTRIES_NUM - 1) : top_q - 1'b1;

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			top_q   <= '0;
			count_q <= '0;
		end else if (push_req && !pop_req) begin
			top_q <= top_next; // wraps over the oldest entry when full
			if (count_q != CNT_W'(ENTRIES_NUM)) begin
				count_q <= count_q + 1'b1;
			end
		end else if (pop_req && !push_req) begin
			top_q   <= top_prev;
			count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push_req && pop_req) begin
			stack_q[top_q] <= push_data; // replace top
		end else if (push_req) begin
			stack_q[top_next] <= push_data;
		end
	end

	// predictor only pops when it saw a valid top
	assert property (@(posedge clk) disable iff (reset) pop_req |-> ras_valid)
		else $error("return address stack popped while empty");

endmodule

`default_nettype wire

/* branch_predictor/branch_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_predictor #(
	parameter int BHT_SIZE = 1024,
	parameter int BTB_SIZE = 8,
	parameter int RAS_SIZE = 8
) (
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic                                         flush,
	input  logic                                         stall_s1,
	input  logic [31:0]                                  pc, // 8-byte aligned
	input  logic [cpu_pkg::FETCH_NUM-1:0][31:0]          instr,
	input  logic [cpu_pkg::FETCH_NUM-1:0]                instr_valid,
	input  logic                                         upd_valid,
	input  logic [31:0]                                  upd_pc,
	input  logic [31:0]                                  upd_target,
	input  logic                                         upd_taken,
	input  logic                                         upd_mispredict,
	input  logic                                         upd_update_bht,
	input  cpu_pkg::controlflow_t                        upd_cf,
	output logic                                         valid,
	output logic [31:0]                                  predict_vaddr,
	output logic [cpu_pkg::FETCH_NUM-1:0]                maybe_jump,
	output cpu_pkg::controlflow_t [cpu_pkg::FETCH_NUM-1:0] cf
);

	logic [cpu_pkg::FETCH_NUM-1:0][31:0] imm_branch;
	logic [cpu_pkg::FETCH_NUM-1:0][31:0] imm_jump;
	logic [cpu_pkg::FETCH_NUM-1:0] dec_branch, dec_return, dec_call, dec_jump_i, dec_jump_r;
	logic [cpu_pkg::FETCH_NUM-1:0] is_branch, is_return, is_call, is_jump_i, is_jump_r;

	logic [cpu_pkg::FETCH_NUM-1:0]       bht_valid;
	logic [cpu_pkg::FETCH_NUM-1:0]       bht_taken_pred;
	logic [cpu_pkg::FETCH_NUM-1:0]       btb_hit;
	logic [cpu_pkg::FETCH_NUM-1:0][31:0] btb_target_pred;
	logic                                ras_valid;
	logic [31:0]                         ras_top;

	logic        ras_push;
	logic        ras_pop;
	logic [31:0] ras_push_data;
	logic        bht_we;
	logic        btb_we;

	for (genvar i = 0; i < cpu_pkg::FETCH_NUM; i++) begin : gen_slot
		branch_decoder decoder_i (
			.instr      (instr[i]),
			.imm_branch (imm_branch[i]),
			.imm_jump   (imm_jump[i]),
			.is_branch  (dec_branch[i]),
			.is_return  (dec_return[i]),
			.is_call    (dec_call[i]),
			.is_jump_i  (dec_jump_i[i]),
			.is_jump_r  (dec_jump_r[i])
		);

		assign is_branch[i] = instr_valid[i] & dec_branch[i];
		assign is_return[i] = instr_valid[i] & dec_return[i];
		assign is_call[i]   = instr_valid[i] & dec_call[i];
		assign is_jump_i[i] = instr_valid[i] & dec_jump_i[i];
		assign is_jump_r[i] = instr_valid[i] & dec_jump_r[i] & ~dec_return[i]; // jr $ra uses the RAS

		assign maybe_jump[i] = instr_valid[i]
			& (dec_branch[i] | dec_return[i] | dec_call[i] | dec_jump_i[i] | dec_jump_r[i]);

		// the decoder classes must not overlap or the scan below picks arbitrarily
		assert property (@(posedge clk) disable iff (reset)
			$onehot0({is_branch[i], is_return[i], is_jump_i[i]}))
			else $error("slot %0d decoded into more than one control-flow class", i);
	end

	// high slot first so the oldest redirecting slot sets the target last
	always_comb begin
		logic taken;

		predict_vaddr = '0;
		ras_push      = 1'b0;
		ras_pop       = 1'b0;
		ras_push_data = '0;
		valid         = 1'b0;
		taken         = 1'b0;
		for (int i = 0; i < cpu_pkg::FETCH_NUM; i++) begin
			cf[i] = cpu_pkg::ControlFlow_None;
		end

		for (int i = cpu_pkg::FETCH_NUM - 1; i >= 0; i--) begin
			taken = bht_valid[i] ? bht_taken_pred[i] : imm_branch[i][31]; // static: backward taken
			if (is_return[i]) begin
				cf[i]         = cpu_pkg::ControlFlow_JumpReg;
				predict_vaddr = ras_top;
				ras_pop       = ras_pop | ras_valid;
			end else if (is_jump_i[i]) begin
				cf[i]         = cpu_pkg::ControlFlow_JumpImm;
				predict_vaddr = {pc[31:28], imm_jump[i][27:0]};
			end else if (is_branch[i] && taken) begin
				cf[i]         = cpu_pkg::ControlFlow_Branch;
				predict_vaddr = pc + 32'(4 * i + 4) + imm_branch[i];
			end else if (is_jump_r[i] && btb_hit[i]) begin
				cf[i]         = cpu_pkg::ControlFlow_JumpReg;
				predict_vaddr = btb_target_pred[i];
			end

			if (is_call[i]) begin
				ras_push      = 1'b1;
				ras_push_data = pc + 32'(4 * i + 8); // skip the delay slot
			end
			valid = valid | (cf[i] != cpu_pkg::ControlFlow_None);
		end
	end

	assign bht_we = upd_valid & upd_update_bht;
	assign btb_we = upd_valid & upd_mispredict & (upd_cf == cpu_pkg::ControlFlow_JumpReg);

	bht #(
		.ENTRIES_NUM (BHT_SIZE)
	) bht_i (
		.clk            (clk),
		.reset          (reset),
		.pc             (pc),
		.bht_we         (bht_we),
		.bht_pc         (upd_pc),
		.bht_taken      (upd_taken),
		.bht_valid      (bht_valid),
		.bht_taken_pred (bht_taken_pred)
	);

	btb #(
		.ENTRIES_NUM (BTB_SIZE)
	) btb_i (
		.clk             (clk),
		.reset           (reset),
		.pc              (pc),
		.btb_we          (btb_we),
		.btb_pc          (upd_pc),
		.btb_target      (upd_target),
		.btb_hit         (btb_hit),
		.btb_target_pred (btb_target_pred)
	);

	ras #(
		.ENTRIES_NUM (RAS_SIZE)
	) ras_i (
		.clk       (clk),
		.reset     (reset),
		.flush     (flush),
		.push_req  (ras_push & ~stall_s1),
		.pop_req   (ras_pop & ~stall_s1),
		.push_data (ras_push_data),
		.ras_valid (ras_valid),
		.ras_top   (ras_top)
	);

endmodule

`default_nettype wire

/* source/resolve_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module resolve_queue (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  flush,
	input  logic                  res_valid,
	input  logic [31:0]           res_pc,
	input  logic [31:0]           res_target,
	input  logic                  res_taken,
	input  logic                  res_mispredict,
	input  logic                  res_update_bht,
	input  cpu_pkg::controlflow_t res_cf,
	output logic                  upd_valid,
	output logic [31:0]           upd_pc,
	output logic [31:0]           upd_target,
	output logic                  upd_taken,
	output logic                  upd_mispredict,
	output logic                  upd_update_bht,
	output cpu_pkg::controlflow_t upd_cf,
	output logic                  credit_return
);

	logic [31:0]           pc_q         [cpu_pkg::RESOLVE_DEPTH];
	logic [31:0]           target_q     [cpu_pkg::RESOLVE_DEPTH];
	logic                  taken_q      [cpu_pkg::RESOLVE_DEPTH];
	logic                  mispredict_q [cpu_pkg::RESOLVE_DEPTH];
	logic                  update_bht_q [cpu_pkg::RESOLVE_DEPTH];
	cpu_pkg::controlflow_t cf_q         [cpu_pkg::RESOLVE_DEPTH];

	logic [$clog2(cpu_pkg::RESOLVE_DEPTH)-1:0]   wr_ptr_q;
	logic [$clog2(cpu_pkg::RESOLVE_DEPTH)-1:0]   rd_ptr_q;
	logic [$clog2(cpu_pkg::RESOLVE_DEPTH+1)-1:0] count_q;
	logic                                        full;
	logic                                        push;
	logic                                        pop;

	assign full = (count_q == cpu_pkg::RESOLVE_DEPTH);
	assign push = res_valid & ~full;
	assign pop  = (count_q != '0) & ~flush; // entries wait out a flush

	assign upd_valid      = pop;
	assign credit_return  = pop; // one credit back per drained entry
	assign upd_pc         = pc_q[rd_ptr_q];
	assign upd_target     = target_q[rd_ptr_q];
	assign upd_taken      = taken_q[rd_ptr_q];
	assign upd_mispredict = mispredict_q[rd_ptr_q];
	assign upd_update_bht = update_bht_q[rd_ptr_q];
	assign upd_cf         = cf_q[rd_ptr_q];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			pc_q[wr_ptr_q]         <= res_pc;
			target_q[wr_ptr_q]     <= res_target;
			taken_q[wr_ptr_q]      <= res_taken;
			mispredict_q[wr_ptr_q] <= res_mispredict;
			update_bht_q[wr_ptr_q] <= res_update_bht;
			cf_q[wr_ptr_q]         <= res_cf;
		end
	end

	// back end spent a credit it did not hold
	assert property (@(posedge clk) disable iff (reset) res_valid |-> !full)
		else $error("resolve report arrived while the queue was full");

endmodule

`default_nettype wire

/* source/fetch_predict_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_predict_top (
	input  logic                                           clk,
	input  logic                                           reset,
	input  logic                                           flush,
	input  logic                                           stall_s1,
	input  logic [31:0]                                    pc,
	input  logic [cpu_pkg::FETCH_NUM-1:0][31:0]            instr,
	input  logic [cpu_pkg::FETCH_NUM-1:0]                  instr_valid,
	input  logic                                           res_valid,
	input  logic [31:0]                                    res_pc,
	input  logic [31:0]                                    res_target,
	input  logic                                           res_taken,
	input  logic                                           res_mispredict,
	input  logic                                           res_update_bht,
	input  cpu_pkg::controlflow_t                          res_cf,
	output logic                                           credit_return,
	output logic                                           valid,
	output logic [31:0]                                    predict_vaddr,
	output logic [cpu_pkg::FETCH_NUM-1:0]                  maybe_jump,
	output cpu_pkg::controlflow_t [cpu_pkg::FETCH_NUM-1:0] cf
);

	logic                  upd_valid;
	logic [31:0]           upd_pc;
	logic [31:0]           upd_target;
	logic                  upd_taken;
	logic                  upd_mispredict;
	logic                  upd_update_bht;
	cpu_pkg::controlflow_t upd_cf;

	resolve_queue resolve_queue_i (
		.clk            (clk),
		.reset          (reset),
		.flush          (flush),
		.res_valid      (res_valid),
		.res_pc         (res_pc),
		.res_target     (res_target),
		.res_taken      (res_taken),
		.res_mispredict (res_mispredict),
		.res_update_bht (res_update_bht),
		.res_cf         (res_cf),
		.upd_valid      (upd_valid),
		.upd_pc         (upd_pc),
		.upd_target     (upd_target),
		.upd_taken      (upd_taken),
		.upd_mispredict (upd_mispredict),
		.upd_update_bht (upd_update_bht),
		.upd_cf         (upd_cf),
		.credit_return  (credit_return)
	);

	branch_predictor branch_predictor_i (
		.clk            (clk),
		.reset          (reset),
		.flush          (flush),
		.stall_s1       (stall_s1),
		.pc             (pc),
		.instr          (instr),
		.instr_valid    (instr_valid),
		.upd_valid      (upd_valid),
		.upd_pc         (upd_pc),
		.upd_target     (upd_target),
		.upd_taken      (upd_taken),
		.upd_mispredict (upd_mispredict),
		.upd_update_bht (upd_update_bht),
		.upd_cf         (upd_cf),
		.valid          (valid),
		.predict_vaddr  (predict_vaddr),
		.maybe_jump     (maybe_jump),
		.cf             (cf)
	);

endmodule

`default_nettype wire

/* tb/tb_fetch_predict.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_predict;

	localparam int    CLK_PERIOD   = 10;
	localparam int    RESET_CYCLES = 5;
	localparam string VECTOR_FILE  = "tb/predict_vectors.txt";

	// one fetch cycle of stimulus and the outputs expected in that cycle
	typedef struct {
		string       name;
		logic [31:0] pc;
		logic [31:0] instr0;
		logic [31:0] instr1;
		logic [1:0]  instr_valid;
		logic        stall_s1;
		logic        flush;
		logic        res_valid;
		logic [31:0] res_pc;
		logic [31:0] res_target;
		logic        res_taken;
		logic        res_mispredict;
		logic        res_update_bht;
		logic [1:0]  res_cf;
		logic        exp_valid;
		logic [31:0] exp_vaddr;
		logic [1:0]  exp_cf0;
		logic [1:0]  exp_cf1;
		logic [1:0]  exp_maybe_jump;
		logic        exp_credit;
	} vector_t;

	logic                                           clk = 1'b0;
	logic                                           reset;
	logic                                           flush;
	logic                                           stall_s1;
	logic [31:0]                                    pc;
	logic [cpu_pkg::FETCH_NUM-1:0][31:0]            instr;
	logic [cpu_pkg::FETCH_NUM-1:0]                  instr_valid;
	logic                                           res_valid;
	logic [31:0]                                    res_pc;
	logic [31:0]                                    res_target;
	logic                                           res_taken;
	logic                                           res_mispredict;
	logic                                           res_update_bht;
	cpu_pkg::controlflow_t                          res_cf;
	logic                                           credit_return;
	logic                                           valid;
	logic [31:0]                                    predict_vaddr;
	logic [cpu_pkg::FETCH_NUM-1:0]                  maybe_jump;
	cpu_pkg::controlflow_t [cpu_pkg::FETCH_NUM-1:0] cf;

	vector_t vectors[$];
	logic    vectors_loaded = 1'b0;
	int      mismatch_count = 0;
	int      other_count    = 0;

	fetch_predict_top dut_i (
		.clk            (clk),
		.reset          (reset),
		.flush          (flush),
		.stall_s1       (stall_s1),
		.pc             (pc),
		.instr          (instr),
		.instr_valid    (instr_valid),
		.res_valid      (res_valid),
		.res_pc         (res_pc),
		.res_target     (res_target),
		.res_taken      (res_taken),
		.res_mispredict (res_mispredict),
		.res_update_bht (res_update_bht),
		.res_cf         (res_cf),
		.credit_return  (credit_return),
		.valid          (valid),
		.predict_vaddr  (predict_vaddr),
		.maybe_jump     (maybe_jump),
		.cf             (cf)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic load_vectors();
		int      fd;
		int      n;
		string   line;
		vector_t v;

		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			$display("could not open the vector file %s", VECTOR_FILE);
			other_count++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.getc(0) == "#") begin
				continue; // column notes and test names
			end
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				v.name, v.pc, v.instr0, v.instr1, v.instr_valid, v.stall_s1, v.flush,
				v.res_valid, v.res_pc, v.res_target, v.res_taken, v.res_mispredict,
				v.res_update_bht, v.res_cf, v.exp_valid, v.exp_vaddr, v.exp_cf0,
				v.exp_cf1, v.exp_maybe_jump, v.exp_credit);
			if (n <= 0) begin
				continue; // blank line
			end
			if (n != 20) begin
				$display("vector line has %0d fields instead of 20: %s", n, line);
				other_count++;
			end else begin
				vectors.push_back(v);
			end
		end
		$fclose(fd);
		if (vectors.size() == 0) begin
			$display("the vector file %s holds no vectors", VECTOR_FILE);
			other_count++;
		end
	endtask

	// invalid slots get random words, the DUT must ignore them
	task automatic apply_inputs(input vector_t v);
		pc             <= v.pc;
		instr[0]       <= v.instr_valid[0] ? v.instr0 : $urandom();
		instr[1]       <= v.instr_valid[1] ? v.instr1 : $urandom();
		instr_valid    <= v.instr_valid;
		stall_s1       <= v.stall_s1;
		flush          <= v.flush;
		res_valid      <= v.res_valid;
		res_pc         <= v.res_pc;
		res_target     <= v.res_target;
		res_taken      <= v.res_taken;
		res_mispredict <= v.res_mispredict;
		res_update_bht <= v.res_update_bht;
		res_cf         <= cpu_pkg::controlflow_t'(v.res_cf);
	endtask

	task automatic check_field(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("mismatch in %s: %s expected %h, actual %h", test, field, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic compare_outputs(input vector_t v);
		check_field(v.name, "valid", 32'(v.exp_valid), 32'(valid));
		check_field(v.name, "predict_vaddr", v.exp_vaddr, predict_vaddr);
		check_field(v.name, "cf0", 32'(v.exp_cf0), 32'(cf[0]));
		check_field(v.name, "cf1", 32'(v.exp_cf1), 32'(cf[1]));
		check_field(v.name, "maybe_jump", 32'(v.exp_maybe_jump), 32'(maybe_jump));
		check_field(v.name, "credit_return", 32'(v.exp_credit), 32'(credit_return));
	endtask

	initial begin
		void'($urandom(32'h03df_fa12));
		reset          = 1'b1;
		flush          = 1'b0;
		stall_s1       = 1'b0;
		pc             = '0;
		instr          = '0;
		instr_valid    = '0;
		res_valid      = 1'b0;
		res_pc         = '0;
		res_target     = '0;
		res_taken      = 1'b0;
		res_mispredict = 1'b0;
		res_update_bht = 1'b0;
		res_cf         = cpu_pkg::ControlFlow_None;
		load_vectors();
		vectors_loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		foreach (vectors[k]) begin
			apply_inputs(vectors[k]);
			#(CLK_PERIOD - 2); // outputs settled, next edge not yet reached
			compare_outputs(vectors[k]);
			@(posedge clk);
		end

		$display("error summary: %0d mismatches, %0d other errors", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// watchdog, sized from the vector count
	initial begin
		wait (vectors_loaded);
		#((vectors.size() + 20) * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d clock cycles", vectors.size() + 20);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/predict_vectors.txt */
# columns (hex): name pc instr0 instr1 instr_valid stall_s1 flush res_valid res_pc res_target
#   res_taken res_mispredict res_update_bht res_cf exp_valid exp_vaddr exp_cf0 exp_cf1 exp_maybe_jump exp_credit
# static prediction and decode
st_back      00001000 1000fffc 00000000 3 0 0 0 00000000 00000000 0 0 0 0 1 00000ff4 1 0 1 0
st_fwd       00001008 10000008 24080001 3 0 0 0 00000000 00000000 0 0 0 0 0 00000000 0 0 1 0
st_slot1     00001010 00000000 1400fffe 3 0 0 0 00000000 00000000 0 0 0 0 1 00001010 0 1 2 0
st_invalid   00001018 1000fffc 1000fffc 2 0 0 0 00000000 00000000 0 0 0 0 1 00001010 0 1 2 0
st_none      00001020 1000fffc 0c000800 0 0 0 0 00000000 00000000 0 0 0 0 0 00000000 0 0 0 0
# jumps and priority
jmp_slot1    40001000 00000000 08012340 3 0 0 0 00000000 00000000 0 0 0 0 1 40048d00 0 2 2 0
jmp_prio     40002000 1000fff0 08012340 3 0 0 0 00000000 00000000 0 0 0 0 1 40001fc4 1 2 3 0
# call and return
call_s1      00002000 00000000 0c000800 3 0 0 0 00000000 00000000 0 0 0 0 1 00002000 0 2 2 0
ret_1        00003000 03e00008 00000000 3 0 0 0 00000000 00000000 0 0 0 0 1 0000200c 3 0 1 0
call_s0      00002100 0c000900 00000000 3 0 0 0 00000000 00000000 0 0 0 0 1 00002400 2 0 1 0
ret_stall    00003008 03e00008 00000000 3 1 0 0 00000000 00000000 0 0 0 0 1 00002108 3 0 1 0
call_stall   00002200 0c000a00 00000000 3 1 0 0 00000000 00000000 0 0 0 0 1 00002800 2 0 1 0
ret_2        00003010 03e00008 00000000 3 0 0 0 00000000 00000000 0 0 0 0 1 00002108 3 0 1 0
call_pre     00002300 0c000b00 00000000 3 0 0 0 00000000 00000000 0 0 0 0 1 00002c00 2 0 1 0
ras_flush    00004000 00000000 00000000 3 0 1 0 00000000 00000000 0 0 0 0 0 00000000 0 0 0 0
ret_empty    00003018 03e00008 00000000 3 0 0 0 00000000 00000000 0 0 0 0 1 00000000 3 0 1 0
# bht training
bht_rep1     00005040 1000fffc 00000000 3 0 0 1 00005040 00005034 0 1 1 1 1 00005034 1 0 1 0
bht_rep2     00005040 1000fffc 00000000 3 0 0 1 00005040 00005034 0 1 1 1 1 00005034 1 0 1 1
bht_nt1      00005040 1000fffc 00000000 3 0 0 0 00000000 00000000 0 0 0 0 0 00000000 0 0 1 1
bht_nt2      00005040 1000fffc 00000000 3 0 0 0 00000000 00000000 0 0 0 0 0 00000000 0 0 1 0
bht_tk_rep1  00005040 1000fffc 00000000 3 0 0 1 00005040 00005034 1 1 1 1 0 00000000 0 0 1 0
bht_tk_rep2  00005040 1000fffc 00000000 3 0 0 1 00005040 00005034 1 1 1 1 0 00000000 0 0 1 1
bht_tk1      00005040 1000fffc 00000000 3 0 0 0 00000000 00000000 0 0 0 0 0 00000000 0 0 1 1
bht_tk2      00005040 1000fffc 00000000 3 0 0 0 00000000 00000000 0 0 0 0 1 00005034 1 0 1 0
# btb fill
btb_miss     00006000 00000000 01000008 3 0 0 1 00006004 00007700 1 0 0 3 0 00000000 0 0 2 0
btb_ok_drain 00006000 00000000 01000008 3 0 0 0 00000000 00000000 0 0 0 0 0 00000000 0 0 2 1
btb_misp     00006000 00000000 01000008 3 0 0 1 00006004 00007700 1 1 0 3 0 00000000 0 0 2 0
btb_fill     00006000 00000000 01000008 3 0 0 0 00000000 00000000 0 0 0 0 0 00000000 0 0 2 1
btb_hit      00006000 00000000 01000008 3 0 0 0 00000000 00000000 0 0 0 0 1 00007700 0 3 2 0
# credits
crd_1        00007000 00000000 00000000 3 0 0 1 00007100 00007200 1 0 0 1 0 00000000 0 0 0 0
crd_2        00007000 00000000 00000000 3 0 0 1 00007108 00007200 1 0 0 1 0 00000000 0 0 0 1
crd_3        00007000 00000000 00000000 3 0 0 1 00007110 00007200 1 0 0 1 0 00000000 0 0 0 1
crd_4        00007000 00000000 00000000 3 0 0 1 00007118 00007200 1 0 0 1 0 00000000 0 0 0 1
crd_drain    00007000 00000000 00000000 3 0 0 0 00000000 00000000 0 0 0 0 0 00000000 0 0 0 1
fl_rep1      00007000 00000000 00000000 3 0 1 1 00007120 00007200 1 0 0 1 0 00000000 0 0 0 0
fl_rep2      00007000 00000000 00000000 3 0 1 1 00007128 00007200 1 0 0 1 0 00000000 0 0 0 0
fl_hold      00007000 00000000 00000000 3 0 1 0 00000000 00000000 0 0 0 0 0 00000000 0 0 0 0
fl_rel1      00007000 00000000 00000000 3 0 0 0 00000000 00000000 0 0 0 0 0 00000000 0 0 0 1
fl_rel2      00007000 00000000 00000000 3 0 0 0 00000000 00000000 0 0 0 0 0 00000000 0 0 0 1
crd_idle     00007000 00000000 00000000 3 0 0 0 00000000 00000000 0 0 0 0 0 00000000 0 0 0 0

/* compile.f */
common/cpu_pkg.sv
source/branch_decoder.sv
branch_predictor/bht.sv
branch_predictor/btb.sv
branch_predictor/ras.sv
branch_predictor/branch_predictor.sv
source/resolve_queue.sv
source/fetch_predict_top.sv
tb/tb_fetch_predict.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_fetch_predict -o sim_fetch_predict

./obj_dir/sim_fetch_predict | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
exit 0
